/* blast_defines.svh */
`ifndef BLAST_DEFINES_SVH
`define BLAST_DEFINES_SVH

// memory port
`define BLAST_MEM_WIDTH 64
`define BLAST_ADDR_WIDTH 14

// nucleotide code
`define BLAST_SYMBOL_WIDTH 3

// block sizes in memory words
`define BLAST_QUERY_WORDS 6
`define BLAST_SUBJECT_WORDS 3

// seed matcher
`define BLAST_SEED_LEN 4
`define BLAST_HIT_FIFO_DEPTH 8

// memory map
`define BLAST_QUERY_ADDR 0
`define BLAST_SUBJECT_ADDR 12
// hit records start one word above the hit header
`define BLAST_HIT_ADDR 16262

// command codes
`define BLAST_CMD_LOAD_QUERY 8'hAA
`define BLAST_CMD_SCAN_SUBJECT 8'hBB

`endif

/* blast_pkg.sv */
`default_nettype none
`include "blast_defines.svh"

package blast_pkg;

   typedef logic [`BLAST_SYMBOL_WIDTH-1:0] symbol_t;
   typedef logic [`BLAST_ADDR_WIDTH-1:0] mem_addr_t;
   typedef logic [`BLAST_MEM_WIDTH-1:0] mem_word_t;

   typedef logic [`BLAST_QUERY_WORDS*`BLAST_MEM_WIDTH-1:0] query_block_t;
   typedef logic [`BLAST_SUBJECT_WORDS*`BLAST_MEM_WIDTH-1:0] subject_block_t;

   typedef logic [7:0] query_pos_t;
   typedef logic [31:0] subject_pos_t;
   typedef logic [15:0] match_count_t;

   // query position is zero-extended into 16 bits
   typedef struct packed {
      subject_pos_t subject_pos;
      logic [15:0] query_pos;
      match_count_t match_count;
   } hit_word_t;

   // also the hit header, with the hit count in the length field
   typedef struct packed {
      logic [31:0] id;
      logic [31:0] length;
   } subject_header_t;

endpackage

`default_nettype wire

/* block_streamer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "blast_defines.svh"

module block_streamer #(
   parameter type block_t = blast_pkg::query_block_t
) (
   input wire clk,
   input wire reset,
   input wire load,
   input wire load_done,
   input wire blast_pkg::mem_word_t word,
   output blast_pkg::symbol_t sym,
   output logic sym_valid,
   input wire sym_ready,
   output logic sym_done
);

   import blast_pkg::*;

   localparam int BLOCK_BITS = $bits(block_t);
   localparam int SYM_W = `BLAST_SYMBOL_WIDTH;
   localparam int NUM_SYMS = BLOCK_BITS / SYM_W;
   localparam int CNT_W = $clog2(NUM_SYMS + 1);

   block_t block_q;
   logic load_q;
   logic [CNT_W-1:0] left_q;
   logic take;

   // symbol 0 always sits in the lowest bits
   assign sym = block_q[SYM_W-1:0];
   assign sym_valid = (left_q != '0);
   assign take = sym_valid && sym_ready;
   assign sym_done = take && (left_q == CNT_W'(1));

   always_ff @(posedge clk) begin
      if (reset) begin
         load_q <= 1'b0;
         left_q <= '0;
      end else begin
         // read data lags the strobe by one cycle
         load_q <= load;
         if (load_done) begin
            left_q <= CNT_W'(NUM_SYMS);
         end else if (take) begin
            left_q <= left_q - 1'b1;
         end
      end
   end

   // first word read ends up lowest
   always_ff @(posedge clk) begin
      if (load_q) begin
         block_q <= {word, block_q[BLOCK_BITS-1:`BLAST_MEM_WIDTH]};
      end else if (take) begin
         block_q <= block_q >> SYM_W;
      end
   end

endmodule

`default_nettype wire

/* seed_matcher.sv */
`timescale 1ns/1ps
`default_nettype none
`include "blast_defines.svh"

module seed_matcher (
   input wire clk,
   input wire reset,
   input wire new_subject,
   input wire blast_pkg::symbol_t q_sym,
   input wire q_valid,
   input wire blast_pkg::symbol_t s_sym,
   input wire s_valid,
   output logic s_ready,
   output logic hit_valid,
   input wire hit_pop,
   output blast_pkg::hit_word_t hit_word
);

   import blast_pkg::*;

   localparam int SYM_W = `BLAST_SYMBOL_WIDTH;
   localparam int SEED_LEN = `BLAST_SEED_LEN;
   localparam int SEED_BITS = SEED_LEN * SYM_W;
   localparam int QUERY_BITS = $bits(query_block_t);
   localparam int NUM_POS = QUERY_BITS / SYM_W - SEED_LEN + 1;
   localparam int DEPTH = `BLAST_HIT_FIFO_DEPTH;
   localparam int PTR_W = $clog2(DEPTH);

   query_block_t query_q;
   logic [SEED_BITS-1:0] window_q;
   logic [$clog2(SEED_LEN)-1:0] fill_q;
   subject_pos_t s_pos_q;
   logic win_valid_q;
   subject_pos_t win_pos_q;
   logic [NUM_POS-1:0] match_now;
   logic [NUM_POS-1:0] match_q;
   logic match_valid_q;
   subject_pos_t match_pos_q;
   query_pos_t lowest;
   match_count_t n_matches;
   hit_word_t fifo_mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr_q;
   logic [PTR_W-1:0] rd_ptr_q;
   logic [PTR_W:0] count_q;
   logic [PTR_W:0] used_slots;
   logic s_take;
   logic push;
   logic pop;

   // keep a slot for the hit still in the window stage
   assign used_slots = count_q + match_valid_q;
   assign s_ready = (used_slots <= DEPTH - 2);
   assign s_take = s_valid && s_ready;

   always_ff @(posedge clk) begin
      if (q_valid) begin
         query_q <= {q_sym, query_q[QUERY_BITS-1:SYM_W]};
      end
      if (s_take) begin
         window_q <= {s_sym, window_q[SEED_BITS-1:SYM_W]};
         win_pos_q <= s_pos_q - subject_pos_t'(SEED_LEN - 1);
      end
      match_q <= match_now;
      match_pos_q <= win_pos_q;
      if (push) begin
         fifo_mem[wr_ptr_q] <= '{subject_pos: match_pos_q,
                                 query_pos: {8'd0, lowest},
                                 match_count: n_matches};
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         fill_q <= '0;
         s_pos_q <= '0;
         win_valid_q <= 1'b0;
         match_valid_q <= 1'b0;
      end else begin
         win_valid_q <= s_take && (fill_q == SEED_LEN - 1);
         match_valid_q <= win_valid_q;
         if (new_subject) begin
            fill_q <= '0;
            s_pos_q <= '0;
         end else if (s_take) begin
            if (fill_q != SEED_LEN - 1) begin
               fill_q <= fill_q + 1'b1;
            end
            s_pos_q <= s_pos_q + 1'b1;
         end
      end
   end

   // every query position against the window at once
   always_comb begin
      for (int j = 0; j < NUM_POS; j++) begin
         match_now[j] = (query_q[j*SYM_W +: SEED_BITS] == window_q);
      end
   end

   // scan downward so the lowest position wins
   always_comb begin
      lowest = '0;
      n_matches = '0;
      for (int j = NUM_POS - 1; j >= 0; j--) begin
         if (match_q[j]) begin
            lowest = query_pos_t'(j);
            n_matches = n_matches + 1'b1;
         end
      end
   end

   assign push = match_valid_q && (n_matches != '0);
   assign pop = hit_pop && hit_valid;
   assign hit_valid = (count_q != '0);
   assign hit_word = fifo_mem[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= rd_ptr_q + 1'b1;
         end
         case ({push, pop})
            2'b10: count_q <= count_q + 1'b1;
            2'b01: count_q <= count_q - 1'b1;
            default: count_q <= count_q;
         endcase
      end
   end

endmodule

`default_nettype wire

/* seq_controller.sv */
`timescale 1ns/1ps
`default_nettype none
`include "blast_defines.svh"

module seq_controller (
   input wire clk,
   input wire reset,
   input wire cmd_req,
   input wire [7:0] cmd_code,
   output logic cmd_ack,
   output blast_pkg::mem_addr_t mem_addr,
   output logic mem_write,
   output blast_pkg::mem_word_t mem_wdata,
   input wire blast_pkg::mem_word_t mem_rdata,
   output logic query_load,
   output logic query_load_done,
   input wire query_done,
   output logic subject_load,
   output logic subject_load_done,
   input wire subject_done,
   output logic new_subject,
   input wire hit_valid,
   output logic hit_pop,
   input wire blast_pkg::hit_word_t hit_word
);

   import blast_pkg::*;

   localparam int CHUNK_SYMS =
      `BLAST_SUBJECT_WORDS * `BLAST_MEM_WIDTH / `BLAST_SYMBOL_WIDTH;
   // matcher push latency after the last subject symbol
   localparam int PIPE_WAIT = 2;

   typedef enum logic [3:0] {
      IDLE, Q_READ, Q_STREAM, S_HDR, S_READ, S_STREAM, DRAIN, HDR_WRITE, ACK
   } state_t;

   state_t state_q;
   logic cmd_req_q;
   logic hdr_cap_q;
   logic [2:0] cnt_q;
   mem_addr_t rd_addr_q;
   mem_addr_t hit_addr_q;
   logic [31:0] subj_id_q;
   subject_pos_t subj_len_q;
   subject_pos_t sym_total_q;
   logic [31:0] hit_cnt_q;
   subject_header_t header;
   logic req_rise;
   logic pop_ok;

   assign req_rise = cmd_req && !cmd_req_q;
   assign query_load = (state_q == Q_READ);
   assign subject_load = (state_q == S_READ);
   assign new_subject = (state_q == S_HDR);

   // no read is issued in these states
   assign pop_ok = (state_q == S_STREAM) || (state_q == DRAIN);
   assign hit_pop = hit_valid && pop_ok;

   assign header = '{id: subj_id_q, length: hit_cnt_q};
   assign mem_write = hit_pop || (state_q == HDR_WRITE);
   assign mem_wdata = (state_q == HDR_WRITE) ? mem_word_t'(header) : mem_word_t'(hit_word);

   always_comb begin
      if (state_q == HDR_WRITE) begin
         mem_addr = mem_addr_t'(`BLAST_HIT_ADDR);
      end else if (hit_pop) begin
         mem_addr = hit_addr_q;
      end else begin
         mem_addr = rd_addr_q;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state_q <= IDLE;
         cmd_ack <= 1'b0;
         cmd_req_q <= 1'b0;
         hdr_cap_q <= 1'b0;
         cnt_q <= '0;
         query_load_done <= 1'b0;
         subject_load_done <= 1'b0;
      end else begin
         cmd_req_q <= cmd_req;
         hdr_cap_q <= (state_q == S_HDR);
         query_load_done <= 1'b0;
         subject_load_done <= 1'b0;
         case (state_q)
            IDLE: begin
               if (req_rise) begin
                  cnt_q <= '0;
                  case (cmd_code)
                     `BLAST_CMD_LOAD_QUERY: state_q <= Q_READ;
                     `BLAST_CMD_SCAN_SUBJECT: state_q <= S_HDR;
                     default: begin
                        state_q <= ACK;
                        cmd_ack <= 1'b1;
                     end
                  endcase
               end
            end
            Q_READ: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == 3'(`BLAST_QUERY_WORDS - 1)) begin
                  state_q <= Q_STREAM;
                  query_load_done <= 1'b1;
               end
            end
            Q_STREAM: begin
               if (query_done) begin
                  state_q <= ACK;
                  cmd_ack <= 1'b1;
               end
            end
            S_HDR: state_q <= S_READ;
            S_READ: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == 3'(`BLAST_SUBJECT_WORDS - 1)) begin
                  state_q <= S_STREAM;
                  subject_load_done <= 1'b1;
               end
            end
            S_STREAM: begin
               if (subject_done) begin
                  cnt_q <= '0;
                  if (sym_total_q + subject_pos_t'(CHUNK_SYMS) >= subj_len_q) begin
                     state_q <= DRAIN;
                  end else begin
                     state_q <= S_READ;
                  end
               end
            end
            DRAIN: begin
               // let the matcher pipeline settle before checking the FIFO
               if (cnt_q != 3'(PIPE_WAIT)) begin
                  cnt_q <= cnt_q + 1'b1;
               end else if (!hit_valid) begin
                  state_q <= HDR_WRITE;
               end
            end
            HDR_WRITE: begin
               state_q <= ACK;
               cmd_ack <= 1'b1;
            end
            ACK: begin
               if (!cmd_req) begin
                  state_q <= IDLE;
                  cmd_ack <= 1'b0;
               end
            end
            default: state_q <= IDLE;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state_q == IDLE && req_rise) begin
         rd_addr_q <= (cmd_code == `BLAST_CMD_SCAN_SUBJECT) ?
                      mem_addr_t'(`BLAST_SUBJECT_ADDR) : mem_addr_t'(`BLAST_QUERY_ADDR);
         hit_addr_q <= mem_addr_t'(`BLAST_HIT_ADDR + 1);
         hit_cnt_q <= '0;
         sym_total_q <= '0;
      end
      if (state_q == Q_READ || state_q == S_HDR || state_q == S_READ) begin
         rd_addr_q <= rd_addr_q + 1'b1;
      end
      // header word arrives in the first chunk read cycle
      if (hdr_cap_q) begin
         {subj_id_q, subj_len_q} <= mem_rdata;
      end
      if (state_q == S_STREAM && subject_done) begin
         sym_total_q <= sym_total_q + subject_pos_t'(CHUNK_SYMS);
      end
      if (hit_pop) begin
         hit_addr_q <= hit_addr_q + 1'b1;
         hit_cnt_q <= hit_cnt_q + 1'b1;
      end
   end

endmodule

`default_nettype wire

/* blast_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "blast_defines.svh"

module blast_top (
   input wire clk,
   input wire reset,
   input wire cmd_req,
   input wire [7:0] cmd_code,
   output logic cmd_ack,
   output blast_pkg::mem_addr_t mem_addr,
   output logic mem_write,
   output blast_pkg::mem_word_t mem_wdata,
   input wire blast_pkg::mem_word_t mem_rdata
);

   import blast_pkg::*;

   logic query_load;
   logic query_load_done;
   logic subject_load;
   logic subject_load_done;
   logic new_subject;
   symbol_t q_sym;
   logic q_valid;
   logic q_done;
   symbol_t s_sym;
   logic s_valid;
   logic s_ready;
   logic s_done;
   logic hit_valid;
   logic hit_pop;
   hit_word_t hit_word;

   seq_controller seq_controller_i (
      .clk(clk),
      .reset(reset),
      .cmd_req(cmd_req),
      .cmd_code(cmd_code),
      .cmd_ack(cmd_ack),
      .mem_addr(mem_addr),
      .mem_write(mem_write),
      .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata),
      .query_load(query_load),
      .query_load_done(query_load_done),
      .query_done(q_done),
      .subject_load(subject_load),
      .subject_load_done(subject_load_done),
      .subject_done(s_done),
      .new_subject(new_subject),
      .hit_valid(hit_valid),
      .hit_pop(hit_pop),
      .hit_word(hit_word)
   );

   // query link never stalls
   block_streamer #(.block_t(query_block_t)) query_streamer_i (
      .clk(clk),
      .reset(reset),
      .load(query_load),
      .load_done(query_load_done),
      .word(mem_rdata),
      .sym(q_sym),
      .sym_valid(q_valid),
      .sym_ready(1'b1),
      .sym_done(q_done)
   );

   block_streamer #(.block_t(subject_block_t)) subject_streamer_i (
      .clk(clk),
      .reset(reset),
      .load(subject_load),
      .load_done(subject_load_done),
      .word(mem_rdata),
      .sym(s_sym),
      .sym_valid(s_valid),
      .sym_ready(s_ready),
      .sym_done(s_done)
   );

   seed_matcher seed_matcher_i (
      .clk(clk),
      .reset(reset),
      .new_subject(new_subject),
      .q_sym(q_sym),
      .q_valid(q_valid),
      .s_sym(s_sym),
      .s_valid(s_valid),
      .s_ready(s_ready),
      .hit_valid(hit_valid),
      .hit_pop(hit_pop),
      .hit_word(hit_word)
   );

endmodule

`default_nettype wire

/* blast_asserts.sv */
`timescale 1ns/1ps
`default_nettype none
`include "blast_defines.svh"

module blast_asserts (
   input wire clk,
   input wire reset,
   input wire cmd_req,
   input wire cmd_ack,
   input wire blast_pkg::mem_addr_t mem_addr,
   input wire mem_write
);

   import blast_pkg::*;

   // number of failed assertions so far
   int fail_count = 0;

   // ack only answers a pending request
   ack_rise_with_req: assert property (@(posedge clk) disable iff (reset)
      $rose(cmd_ack) |-> cmd_req)
      else begin
         fail_count++;
         $error("cmd_ack rose while cmd_req was low");
      end

   ack_fall_after_req: assert property (@(posedge clk) disable iff (reset)
      $fell(cmd_ack) |-> !$past(cmd_req))
      else begin
         fail_count++;
         $error("cmd_ack fell before cmd_req was dropped");
      end

   // writes belong to a running command
   write_in_command: assert property (@(posedge clk) disable iff (reset)
      mem_write |-> (cmd_req && !cmd_ack))
      else begin
         fail_count++;
         $error("memory write outside of a command");
      end

   write_in_hit_area: assert property (@(posedge clk) disable iff (reset)
      mem_write |-> (mem_addr >= mem_addr_t'(`BLAST_HIT_ADDR)))
      else begin
         fail_count++;
         $error("memory write below the hit area");
      end

endmodule

bind blast_top blast_asserts blast_asserts_i (
   .clk(clk),
   .reset(reset),
   .cmd_req(cmd_req),
   .cmd_ack(cmd_ack),
   .mem_addr(mem_addr),
   .mem_write(mem_write)
);

`default_nettype wire

/* tb_blast_top.sv */
`timescale 1ns/1ps
`default_nettype none
`include "blast_defines.svh"

module tb_blast_top;

   import blast_pkg::*;

   localparam int SYM_W = `BLAST_SYMBOL_WIDTH;
   localparam int MEM_W = `BLAST_MEM_WIDTH;
   localparam int SEED_LEN = `BLAST_SEED_LEN;
   localparam int QUERY_SYMS = `BLAST_QUERY_WORDS * MEM_W / SYM_W;
   localparam int CHUNK_SYMS = `BLAST_SUBJECT_WORDS * MEM_W / SYM_W;
   localparam int MAX_SUBJ = 4 * CHUNK_SYMS;
   localparam int RESET_CYCLES = 5;
   // reads, symbol transfers and one write per possible hit for each command
   localparam int LOAD_CYCLES = `BLAST_QUERY_WORDS + QUERY_SYMS;
   localparam int CHUNK_CYCLES = `BLAST_SUBJECT_WORDS + 2 * CHUNK_SYMS;
   localparam int CMD_OVERHEAD = 8;
   localparam int NUM_LOADS = 3;
   localparam int NUM_SCANS = 5;
   localparam int NUM_CHUNKS = 8;
   localparam int TIMEOUT_CYCLES = 4 * (RESET_CYCLES + NUM_LOADS * (LOAD_CYCLES + CMD_OVERHEAD)
                                        + NUM_SCANS * CMD_OVERHEAD + NUM_CHUNKS * CHUNK_CYCLES);

   typedef hit_word_t hit_q_t[$];

   logic clk;
   logic reset;
   logic cmd_req;
   logic [7:0] cmd_code;
   logic cmd_ack;
   mem_addr_t mem_addr;
   logic mem_write;
   mem_word_t mem_wdata;
   mem_word_t mem_rdata;

   mem_word_t mem [mem_addr_t];
   symbol_t query_syms [QUERY_SYMS];
   symbol_t subject_syms [MAX_SUBJ];
   symbol_t saved_subject [MAX_SUBJ];
   string check_name;
   int check_id;
   hit_q_t check_hits;
   int checks_requested = 0;
   int checks_done = 0;
   int word_errors = 0;
   int hit_errors = 0;
   int header_errors = 0;
   int assert_errors = 0;

   blast_top blast_top_i (
      .clk(clk),
      .reset(reset),
      .cmd_req(cmd_req),
      .cmd_code(cmd_code),
      .cmd_ack(cmd_ack),
      .mem_addr(mem_addr),
      .mem_write(mem_write),
      .mem_wdata(mem_wdata),
      .mem_rdata(mem_rdata)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // unwritten words read back as an address-dependent pattern
   function automatic mem_word_t fill_word(input mem_addr_t addr);
      return {18'h2a5a5, addr, 18'h15a5a, addr};
   endfunction

   function automatic mem_word_t read_mem(input mem_addr_t addr);
      return mem.exists(addr) ? mem[addr] : fill_word(addr);
   endfunction

   // one-cycle read latency
   initial begin
      mem_rdata = '0;
      forever begin
         @(posedge clk);
         if (mem_write) begin
            mem[mem_addr] = mem_wdata;
         end
         mem_rdata <= read_mem(mem_addr);
      end
   end

   // one record per subject window with at least one query match
   function automatic hit_q_t expected_hits(input symbol_t q[QUERY_SYMS],
                                            input symbol_t s[MAX_SUBJ], input int len);
      hit_q_t hits;
      hit_word_t h;
      logic same;
      int n;
      int first;
      for (int p = SEED_LEN - 1; p < len; p++) begin
         n = 0;
         first = 0;
         for (int j = 0; j <= QUERY_SYMS - SEED_LEN; j++) begin
            same = 1'b1;
            for (int k = 0; k < SEED_LEN; k++) begin
               if (q[j + k] !== s[p - SEED_LEN + 1 + k]) same = 1'b0;
            end
            if (same) begin
               if (n == 0) first = j;
               n++;
            end
         end
         if (n != 0) begin
            h.subject_pos = subject_pos_t'(p - SEED_LEN + 1);
            h.query_pos = 16'(first);
            h.match_count = match_count_t'(n);
            hits.push_back(h);
         end
      end
      return hits;
   endfunction

   task automatic check_word(input string name, input mem_word_t exp, input mem_word_t act);
      if (act !== exp) begin
         word_errors++;
         $display("ERROR %s: word expected %h, actual %h", name, exp, act);
      end
   endtask

   task automatic check_hit(input string name, input hit_word_t exp, input hit_word_t act);
      if (act !== exp) begin
         hit_errors++;
         $display("ERROR %s: hit expected pos %0d qpos %0d count %0d, actual pos %0d qpos %0d count %0d",
                  name, exp.subject_pos, exp.query_pos, exp.match_count,
                  act.subject_pos, act.query_pos, act.match_count);
      end
   endtask

   task automatic check_header(input string name, input subject_header_t exp,
                               input subject_header_t act);
      if (act !== exp) begin
         header_errors++;
         $display("ERROR %s: header expected id %0d count %0d, actual id %0d count %0d",
                  name, exp.id, exp.length, act.id, act.length);
      end
   endtask

   initial begin : compare
      mem_addr_t addr;
      subject_header_t hdr;
      forever begin
         wait (checks_requested > checks_done);
         foreach (check_hits[i]) begin
            addr = mem_addr_t'(`BLAST_HIT_ADDR + 1 + i);
            check_hit(check_name, check_hits[i], hit_word_t'(read_mem(addr)));
         end
         // nothing written past the last record
         addr = mem_addr_t'(`BLAST_HIT_ADDR + 1 + check_hits.size());
         check_word(check_name, fill_word(addr), read_mem(addr));
         hdr.id = check_id;
         hdr.length = check_hits.size();
         check_header(check_name, hdr, subject_header_t'(read_mem(`BLAST_HIT_ADDR)));
         checks_done++;
      end
   end

   task automatic run_command(input logic [7:0] code);
      @(posedge clk);
      cmd_code <= code;
      cmd_req <= 1'b1;
      do @(posedge clk); while (!cmd_ack);
      cmd_req <= 1'b0;
      do @(posedge clk); while (cmd_ack);
   endtask

   task automatic load_query();
      query_block_t blk;
      for (int i = 0; i < QUERY_SYMS; i++) blk[i*SYM_W +: SYM_W] = query_syms[i];
      for (int w = 0; w < `BLAST_QUERY_WORDS; w++) begin
         mem[mem_addr_t'(`BLAST_QUERY_ADDR + w)] = blk[w*MEM_W +: MEM_W];
      end
      run_command(`BLAST_CMD_LOAD_QUERY);
   endtask

   task automatic scan_subject(input string name, input int id, input int len);
      subject_block_t blk;
      subject_header_t hdr;
      hdr.id = id;
      hdr.length = len;
      mem[mem_addr_t'(`BLAST_SUBJECT_ADDR)] = hdr;
      for (int c = 0; c < len / CHUNK_SYMS; c++) begin
         for (int i = 0; i < CHUNK_SYMS; i++) begin
            blk[i*SYM_W +: SYM_W] = subject_syms[c*CHUNK_SYMS + i];
         end
         for (int w = 0; w < `BLAST_SUBJECT_WORDS; w++) begin
            mem[mem_addr_t'(`BLAST_SUBJECT_ADDR + 1 + c*`BLAST_SUBJECT_WORDS + w)] =
               blk[w*MEM_W +: MEM_W];
         end
      end
      // old records from earlier scans
      for (int a = `BLAST_HIT_ADDR; a < 2**`BLAST_ADDR_WIDTH; a++) begin
         if (mem.exists(mem_addr_t'(a))) mem.delete(mem_addr_t'(a));
      end
      run_command(`BLAST_CMD_SCAN_SUBJECT);
      check_name = name;
      check_id = id;
      check_hits = expected_hits(query_syms, subject_syms, len);
      checks_requested++;
      wait (checks_done == checks_requested);
   endtask

   task automatic plant_seed(input int spos);
      int qpos;
      qpos = $urandom % (QUERY_SYMS - SEED_LEN + 1);
      for (int k = 0; k < SEED_LEN; k++) subject_syms[spos + k] = query_syms[qpos + k];
   endtask

   initial begin
      void'($urandom(95770));
      reset = 1'b1;
      cmd_req = 1'b0;
      cmd_code = '0;
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;

      foreach (query_syms[i]) query_syms[i] = symbol_t'($urandom % 4);
      load_query();
      foreach (subject_syms[i]) subject_syms[i] = symbol_t'($urandom % 4);
      for (int n = 0; n < 3; n++) plant_seed($urandom % (CHUNK_SYMS - SEED_LEN));
      saved_subject = subject_syms;
      scan_subject("one_chunk", 1, CHUNK_SYMS);

      // filler codes lie outside the query alphabet
      foreach (subject_syms[i]) subject_syms[i] = symbol_t'(4 + $urandom % 4);
      plant_seed(CHUNK_SYMS - 2);
      plant_seed(2 * CHUNK_SYMS - 1);
      plant_seed(3 * CHUNK_SYMS - 3);
      for (int n = 0; n < 4; n++) plant_seed($urandom % (MAX_SUBJ - SEED_LEN));
      scan_subject("four_chunks", 2, MAX_SUBJ);

      foreach (subject_syms[i]) subject_syms[i] = symbol_t'(4 + $urandom % 4);
      scan_subject("no_seed", 4, CHUNK_SYMS);

      foreach (query_syms[i]) query_syms[i] = symbol_t'($urandom % 4);
      load_query();
      subject_syms = saved_subject;
      scan_subject("query_reload", 5, CHUNK_SYMS);

      // runs of seven zeros give many matches per window
      foreach (query_syms[i]) query_syms[i] = (i % 8 == 7) ? symbol_t'(1) : symbol_t'(0);
      load_query();
      foreach (subject_syms[i]) subject_syms[i] = symbol_t'(0);
      scan_subject("dense", 6, CHUNK_SYMS);

      assert_errors = blast_top_i.blast_asserts_i.fail_count;
      $display("errors: word %0d, hit %0d, header %0d, assertion %0d",
               word_errors, hit_errors, header_errors, assert_errors);
      if (word_errors + hit_errors + header_errors + assert_errors == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

   initial begin : watchdog
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

/* files.f */
+incdir+.
blast_pkg.sv
block_streamer.sv
seed_matcher.sv
seq_controller.sv
blast_top.sv
blast_asserts.sv
tb_blast_top.sv

/* Bender.yml */
package:
  name: blast_seed_search

sources:
  - include_dirs:
      - .
    files:
      - blast_pkg.sv
      - block_streamer.sv
      - seed_matcher.sv
      - seq_controller.sv
      - blast_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - blast_asserts.sv
      - tb_blast_top.sv
